// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - files:
      - design/riscv_isa_pkg.sv
      - design/core_pkg.sv
      - design/regfile.sv
      - design/fetch_stage.sv
      - design/decode_stage.sv
      - design/execute_stage.sv
      - design/memory_stage.sv
      - design/hazard_unit.sv
      - design/core.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/core_tb.sv

// ==== design/core.sv ====
`timescale 1ns/1ps
`default_nettype none

module core import core_pkg::*; #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  logic                          clk,
	input  logic                          rst_n,
	// Program loader
	input  logic                          imem_we,
	input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
	input  word_t                         imem_wdata,
	// Protocol controller port
	input  logic                          con_we,
	input  logic [$clog2(DMEM_WORDS)-1:0] con_addr,
	input  word_t                         con_wdata,
	output word_t                         con_rdata
);

	if_id_t    if_id;
	id_ex_t    id_ex;
	ex_mem_t   ex_mem;
	mem_wb_t   mem_wb;
	reg_addr_t id_rs1, id_rs2;
	logic      id_uses_rs2;
	logic      stall, flush_id, flush_ex;
	logic      redirect;	// Taken branch or jump in EXE
	word_t     redirect_pc;
	fwd_sel_e  fwd_a, fwd_b;
	word_t     mem_fwd;

	fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) fetch (
		.clk, .rst_n, .stall, .flush_id, .redirect, .redirect_pc,
		.imem_we, .imem_addr, .imem_wdata, .if_id
	);

	decode_stage decode (
		.clk, .rst_n, .stall, .flush_ex, .if_id, .mem_wb,
		.id_rs1, .id_rs2, .id_uses_rs2, .id_ex
	);

	execute_stage execute (
		.clk, .rst_n, .id_ex, .fwd_a, .fwd_b, .mem_fwd, .mem_wb,
		.redirect, .redirect_pc, .ex_mem
	);

	memory_stage #(.DMEM_WORDS(DMEM_WORDS)) memory (
		.clk, .rst_n, .ex_mem, .con_we, .con_addr, .con_wdata, .con_rdata,
		.mem_fwd, .mem_wb
	);

	// Forwarding, load-use stall and flushes
	hazard_unit hazard (
		.id_rs1, .id_rs2, .id_uses_rs2, .id_ex, .ex_mem, .mem_wb, .redirect,
		.stall, .flush_id, .flush_ex, .fwd_a, .fwd_b
	);

endmodule

`default_nettype wire

// ==== design/core_pkg.sv ====
`default_nettype none

package core_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_e;

	typedef enum logic [1:0] {WB_PC4, WB_ALU, WB_LOAD, WB_IMM} wb_sel_e;	// Write-back source
	typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;		// EXE operand source

	// All zero is a bubble
	typedef struct packed {
		alu_op_e alu_op;
		logic    sel_opa_pc;	// opA = PC, JAL only
		logic    sel_opb_imm;
		logic    is_load;
		logic    is_store;
		logic    is_branch;
		logic    is_jal;
		logic    is_jalr;
		logic    reg_we;
		wb_sel_e wb_sel;
	} ctrl_t;

	//////////////////////////////////////////////////
	// Pipeline registers
	typedef struct packed {
		word_t pc;
		word_t pc4;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		word_t     pc;
		word_t     pc4;
		word_t     rs1_val;
		word_t     rs2_val;
		word_t     imm;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		logic [2:0] funct3;	// Branch condition
		ctrl_t     ctrl;
	} id_ex_t;

	typedef struct packed {
		word_t     pc4;
		word_t     alu_out;
		word_t     store_data;
		word_t     imm;
		reg_addr_t rd;
		ctrl_t     ctrl;
	} ex_mem_t;

	typedef struct packed {
		word_t     wb_data;
		reg_addr_t rd;
		logic      reg_we;
	} mem_wb_t;

endpackage

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import riscv_isa_pkg::*, core_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      stall,
	input  logic      flush_ex,
	input  if_id_t    if_id,
	input  mem_wb_t   mem_wb,	// Register file write
	output reg_addr_t id_rs1,	// To hazard unit
	output reg_addr_t id_rs2,
	output logic      id_uses_rs2,
	output id_ex_t    id_ex
);

	instr_u ins;
	ctrl_t  ctrl;
	word_t  imm;
	word_t  rs1_val;
	word_t  rs2_val;
	logic   rs1_used;	// Low for LUI and JAL
	word_t  imm_i, imm_s, imm_b, imm_u, imm_j;

	// funct3 plus alt bit to ALU op
	function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
		case (f3)
			F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
			F3_SLL:  return ALU_SLL;
			F3_SLT:  return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR:  return ALU_XOR;
			F3_SRL:  return alt ? ALU_SRA : ALU_SRL;
			F3_OR:   return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign ins = if_id.instr;

	// Sign-extended immediates per format
	assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
	assign imm_s = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
	assign imm_b = {{19{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11, ins.b.imm_10_5,
		ins.b.imm_4_1, 1'b0};
	assign imm_u = {ins.uj.imm_20, ins.uj.imm_10_1, ins.uj.imm_11, ins.uj.imm_19_12, 12'b0};
	assign imm_j = {{11{ins.uj.imm_20}}, ins.uj.imm_20, ins.uj.imm_19_12, ins.uj.imm_11,
		ins.uj.imm_10_1, 1'b0};

	always_comb begin
		ctrl        = '0;
		imm         = imm_i;
		rs1_used    = 1'b1;
		id_uses_rs2 = 1'b0;
		case (ins.r.opcode)
			OPC_OP: begin
				ctrl.alu_op = alu_decode(ins.r.funct3, ins.r.funct7 == FUNCT7_ALT);
				ctrl.reg_we = 1'b1;
				ctrl.wb_sel = WB_ALU;
				id_uses_rs2 = 1'b1;
			end
			OPC_OP_IMM: begin	// imm[11:5] marks SRAI only
				ctrl.alu_op      = alu_decode(ins.i.funct3,
					ins.i.funct3 == F3_SRL && ins.r.funct7 == FUNCT7_ALT);
				ctrl.sel_opb_imm = 1'b1;
				ctrl.reg_we      = 1'b1;
				ctrl.wb_sel      = WB_ALU;
			end
			OPC_LUI: begin
				ctrl.reg_we = 1'b1;
				ctrl.wb_sel = WB_IMM;
				imm         = imm_u;
				rs1_used    = 1'b0;
			end
			OPC_LOAD: if (ins.i.funct3 == F3_WORD) begin	// LW only
				ctrl.sel_opb_imm = 1'b1;
				ctrl.is_load     = 1'b1;
				ctrl.reg_we      = 1'b1;
				ctrl.wb_sel      = WB_LOAD;
			end
			OPC_STORE: if (ins.s.funct3 == F3_WORD) begin
				ctrl.sel_opb_imm = 1'b1;
				ctrl.is_store    = 1'b1;
				imm              = imm_s;
				id_uses_rs2      = 1'b1;
			end
			OPC_BRANCH: begin
				ctrl.is_branch = 1'b1;
				imm            = imm_b;
				id_uses_rs2    = 1'b1;
			end
			OPC_JAL: begin	// ALU forms the target pc+imm
				ctrl.sel_opa_pc  = 1'b1;
				ctrl.sel_opb_imm = 1'b1;
				ctrl.is_jal      = 1'b1;
				ctrl.reg_we      = 1'b1;
				imm              = imm_j;
				rs1_used         = 1'b0;
			end
			OPC_JALR: begin
				ctrl.sel_opb_imm = 1'b1;
				ctrl.is_jalr     = 1'b1;
				ctrl.reg_we      = 1'b1;	// Link, wb_sel stays PC+4
			end
			default: ;	// Unknown, bubble
		endcase
	end

	assign id_rs1 = rs1_used ? ins.r.rs1 : '0;	// x0 never hazards
	assign id_rs2 = ins.r.rs2;

	regfile rf (
		.clk     (clk),
		.rst_n   (rst_n),
		.we      (mem_wb.reg_we),
		.waddr   (mem_wb.rd),
		.wdata   (mem_wb.wb_data),
		.raddr_a (id_rs1),
		.raddr_b (id_rs2),
		.rdata_a (rs1_val),
		.rdata_b (rs2_val)
	);

	//////////////////////////////////////////////////
	// ID/EXE register, bubble on stall or flush
	always_ff @(posedge clk) begin
		id_ex.pc      <= if_id.pc;
		id_ex.pc4     <= if_id.pc4;
		id_ex.rs1_val <= rs1_val;
		id_ex.rs2_val <= rs2_val;
		id_ex.imm     <= imm;
		id_ex.rs1     <= id_rs1;
		id_ex.rs2     <= id_rs2;
		id_ex.rd      <= ins.r.rd;
		id_ex.funct3  <= ins.r.funct3;
		if (!rst_n || stall || flush_ex)
			id_ex.ctrl <= '0;
		else
			id_ex.ctrl <= ctrl;
	end

	a_unknown_opcode_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		!(ins.r.opcode inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_LOAD, OPC_STORE,
			OPC_BRANCH, OPC_JAL, OPC_JALR}) |=> id_ex.ctrl == '0);

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage import riscv_isa_pkg::*, core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  id_ex_t   id_ex,
	input  fwd_sel_e fwd_a,
	input  fwd_sel_e fwd_b,
	input  word_t    mem_fwd,	// Non-load result in MEM
	input  mem_wb_t  mem_wb,
	output logic     redirect,
	output word_t    redirect_pc,
	output ex_mem_t  ex_mem
);

	word_t rs1_fwd, rs2_fwd;
	word_t opa, opb;
	word_t alu_out;
	word_t br_target;
	logic  eq, lt, ltu;
	logic  br_cond;

	function automatic word_t fwd_pick(input fwd_sel_e sel, input word_t reg_val,
		input word_t mem_val, input word_t wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign rs1_fwd = fwd_pick(fwd_a, id_ex.rs1_val, mem_fwd, mem_wb.wb_data);
	assign rs2_fwd = fwd_pick(fwd_b, id_ex.rs2_val, mem_fwd, mem_wb.wb_data);	// Store data too
	assign opa     = id_ex.ctrl.sel_opa_pc ? id_ex.pc : rs1_fwd;
	assign opb     = id_ex.ctrl.sel_opb_imm ? id_ex.imm : rs2_fwd;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			ALU_SUB:  alu_out = opa - opb;
			ALU_AND:  alu_out = opa & opb;
			ALU_OR:   alu_out = opa | opb;
			ALU_XOR:  alu_out = opa ^ opb;
			ALU_SLT:  alu_out = {31'b0, $signed(opa) < $signed(opb)};
			ALU_SLTU: alu_out = {31'b0, opa < opb};
			ALU_SLL:  alu_out = opa << opb[4:0];
			ALU_SRL:  alu_out = opa >> opb[4:0];
			ALU_SRA:  alu_out = $signed(opa) >>> opb[4:0];
			default:  alu_out = opa + opb;	// ADD, addresses, jump targets
		endcase
	end

	//////////////////////////////////////////////////
	// Branch resolution
	assign eq        = rs1_fwd == rs2_fwd;
	assign lt        = $signed(rs1_fwd) < $signed(rs2_fwd);
	assign ltu       = rs1_fwd < rs2_fwd;
	assign br_target = id_ex.pc + id_ex.imm;

	always_comb begin
		case (id_ex.funct3)
			F3_BEQ:  br_cond = eq;
			F3_BNE:  br_cond = !eq;
			F3_BLT:  br_cond = lt;
			F3_BGE:  br_cond = !lt;
			F3_BLTU: br_cond = ltu;
			F3_BGEU: br_cond = !ltu;
			default: br_cond = 1'b0;
		endcase
	end

	assign redirect = (id_ex.ctrl.is_branch && br_cond) || id_ex.ctrl.is_jal || id_ex.ctrl.is_jalr;

	always_comb begin
		if (id_ex.ctrl.is_jalr)
			redirect_pc = {alu_out[XLEN-1:1], 1'b0};	// rs1+imm, bit 0 dropped
		else if (id_ex.ctrl.is_jal)
			redirect_pc = alu_out;
		else
			redirect_pc = br_target;
	end

	// EXE/MEM register
	always_ff @(posedge clk) begin
		ex_mem.pc4        <= id_ex.pc4;
		ex_mem.alu_out    <= alu_out;
		ex_mem.store_data <= rs2_fwd;
		ex_mem.imm        <= id_ex.imm;
		ex_mem.rd         <= id_ex.rd;
		if (!rst_n)
			ex_mem.ctrl <= '0;
		else
			ex_mem.ctrl <= id_ex.ctrl;
	end

	a_redirect_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		redirect |-> redirect_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import riscv_isa_pkg::*, core_pkg::*; #(
	parameter int IMEM_WORDS = 256,
	localparam int IAW = $clog2(IMEM_WORDS)
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           stall,
	input  logic           flush_id,
	input  logic           redirect,
	input  word_t          redirect_pc,
	input  logic           imem_we,	// Loader, reset only
	input  logic [IAW-1:0] imem_addr,	// Word address
	input  word_t          imem_wdata,
	output if_id_t         if_id
);

	word_t pc;
	word_t pc4;
	word_t imem [IMEM_WORDS];
	word_t instr;

	assign pc4   = pc + 32'd4;
	assign instr = imem[pc[IAW+1:2]];	// Async read, wraps past the top

	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	// PC; redirect wins, stall holds
	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= '0;
		else if (redirect)
			pc <= redirect_pc;
		else if (!stall)
			pc <= pc4;
	end

	//////////////////////////////////////////////////
	// IF/ID register
	always_ff @(posedge clk) begin
		if (!rst_n || flush_id)
			if_id.instr <= NOP_INSTR;	// Squashed slot
		else if (!stall)
			if_id.instr <= instr;
		if (!stall) begin
			if_id.pc  <= pc;
			if_id.pc4 <= pc4;
		end
	end

	// Loader only runs with the core in reset
	a_imem_we_in_reset: assert property (@(posedge clk) $rose(imem_we) |-> !rst_n);

endmodule

`default_nettype wire

// ==== design/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import core_pkg::*; (
	input  reg_addr_t id_rs1,
	input  reg_addr_t id_rs2,
	input  logic      id_uses_rs2,
	input  id_ex_t    id_ex,
	input  ex_mem_t   ex_mem,
	input  mem_wb_t   mem_wb,
	input  logic      redirect,
	output logic      stall,
	output logic      flush_id,
	output logic      flush_ex,
	output fwd_sel_e  fwd_a,
	output fwd_sel_e  fwd_b
);

	logic load_use;

	// Youngest producer first, x0 never forwarded
	function automatic fwd_sel_e fwd_src(input reg_addr_t rs, input ex_mem_t em,
		input mem_wb_t mw);
		if (rs == '0)
			return FWD_REG;
		if (em.ctrl.reg_we && em.rd == rs)
			return FWD_MEM;
		if (mw.reg_we && mw.rd == rs)
			return FWD_WB;
		return FWD_REG;
	endfunction

	assign fwd_a = fwd_src(id_ex.rs1, ex_mem, mem_wb);
	assign fwd_b = fwd_src(id_ex.rs2, ex_mem, mem_wb);

	// Load in EXE feeding the ID instruction
	assign load_use = id_ex.ctrl.is_load && id_ex.rd != '0 &&
		(id_ex.rd == id_rs1 || (id_uses_rs2 && id_ex.rd == id_rs2));

	assign stall    = load_use && !redirect;	// Squashed slot needs no stall
	assign flush_id = redirect;
	assign flush_ex = redirect;

endmodule

`default_nettype wire

// ==== design/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_stage import core_pkg::*; #(
	parameter int DMEM_WORDS = 256,
	localparam int DAW = $clog2(DMEM_WORDS)
) (
	input  logic           clk,
	input  logic           rst_n,
	input  ex_mem_t        ex_mem,
	input  logic           con_we,
	input  logic [DAW-1:0] con_addr,	// Word address
	input  word_t          con_wdata,
	output word_t          con_rdata,
	output word_t          mem_fwd,
	output mem_wb_t        mem_wb
);

	word_t          dmem [DMEM_WORDS];
	logic [DAW-1:0] core_addr;
	word_t          load_data;
	word_t          wb_data;

	assign core_addr = ex_mem.alu_out[DAW+1:2];
	assign load_data = dmem[core_addr];	// Core port, async read

	// Core store and con port share the array
	always_ff @(posedge clk) begin
		if (ex_mem.ctrl.is_store)
			dmem[core_addr] <= ex_mem.store_data;
		if (con_we)
			dmem[con_addr] <= con_wdata;
		con_rdata <= dmem[con_addr];	// One cycle behind con_addr
	end

	//////////////////////////////////////////////////
	// Write-back select; load value only reaches WB
	always_comb begin
		case (ex_mem.ctrl.wb_sel)
			WB_PC4:  mem_fwd = ex_mem.pc4;
			WB_IMM:  mem_fwd = ex_mem.imm;
			default: mem_fwd = ex_mem.alu_out;
		endcase
		wb_data = (ex_mem.ctrl.wb_sel == WB_LOAD) ? load_data : mem_fwd;
	end

	// MEM/WB register
	always_ff @(posedge clk) begin
		mem_wb.wb_data <= wb_data;
		mem_wb.rd      <= ex_mem.rd;
		if (!rst_n)
			mem_wb.reg_we <= 1'b0;
		else
			mem_wb.reg_we <= ex_mem.ctrl.reg_we;
	end

	a_no_port_collision: assert property (@(posedge clk) disable iff (!rst_n)
		!(con_we && ex_mem.ctrl.is_store && con_addr == core_addr));

endmodule

`default_nettype wire

// ==== design/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile import core_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      we,
	input  reg_addr_t waddr,
	input  word_t     wdata,
	input  reg_addr_t raddr_a,
	input  reg_addr_t raddr_b,
	output word_t     rdata_a,
	output word_t     rdata_b
);

	word_t regs [1:31];	// No storage for x0

	// One read port, WB write shows through in the same cycle
	function automatic word_t read_port(input reg_addr_t ra);
		if (ra == '0)
			return '0;
		if (we && ra == waddr)
			return wdata;
		return regs[ra];
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 1; k < 32; k++)
				regs[k] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	always_comb begin
		rdata_a = read_port(raddr_a);
		rdata_b = read_port(raddr_b);
	end

endmodule

`default_nettype wire

// ==== design/riscv_isa_pkg.sv ====
`default_nettype none

package riscv_isa_pkg;

	// Major opcodes, RV32I subset
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	// ALU funct3
	localparam logic [2:0] F3_ADD  = 3'b000;	// ADD/SUB
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SRL  = 3'b101;	// SRL/SRA
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// Branch conditions
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_WORD    = 3'b010;		// LW/SW width, the only one kept
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;	// SUB, SRA, SRAI

	//////////////////////////////////////////////////
	// Instruction formats, MSB first
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_type_t;

	typedef struct packed {
		logic [6:0] imm_hi;	// imm[11:5]
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;	// imm[4:0]
		logic [6:0] opcode;
	} s_type_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_type_t;

	// J layout; LUI takes the same 20 bits in order
	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} uj_type_t;

	typedef union packed {
		r_type_t  r;
		i_type_t  i;
		s_type_t  s;
		b_type_t  b;
		uj_type_t uj;
	} instr_u;

	localparam logic [31:0] NOP_INSTR = 32'h0000_0013;	// ADDI x0,x0,0

endpackage

`default_nettype wire

// ==== sim/core_tb_programs.svh ====
`ifndef CORE_TB_PROGRAMS_SVH
`define CORE_TB_PROGRAMS_SVH

localparam int N_PROGS      = 6;
localparam int PROG_WORDS   = 32;	// NOP padded words per program
localparam int PRELOAD_WORD = 8;	// Byte address 32

// Major opcodes for the I-type helper
localparam logic [6:0] OP_IMM  = 7'b0010011;
localparam logic [6:0] OP_LOAD = 7'b0000011;
localparam logic [6:0] OP_JALR = 7'b1100111;

// One table row
typedef struct packed {
	logic [2:0]  prog;
	logic        pre_en;	// Con preload before the run
	logic [7:0]  pre_addr;
	logic [31:0] pre_val;
	logic [7:0]  res_addr;	// Word read back over con
	logic [31:0] expected;
} test_t;

logic [31:0] prog_mem [N_PROGS][PROG_WORDS];
int          prog_len [N_PROGS];
test_t       tests [$];
string       test_names [$];

//////////////////////////////////////////////////
// RV32I base format encoders
function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
	input int rd, input int rs1, input int rs2);
	return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
	input int rd, input int rs1, input int imm);
	return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
endfunction

function automatic logic [31:0] store_word(input int rs2, input int rs1, input int imm);
	return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] branch_word(input logic [2:0] f3, input int rs1,
	input int rs2, input int imm);
	return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] jal_word(input int rd, input int imm);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

function automatic logic [31:0] lui_word(input int rd, input logic [19:0] imm20);
	return {imm20, rd[4:0], 7'b0110111};
endfunction

task automatic emit(input int p, input logic [31:0] w);
	prog_mem[p][prog_len[p]] = w;
	prog_len[p]++;
endtask

//////////////////////////////////////////////////
// Programs that each park in a jump to itself
task automatic build_programs();
	for (int p = 0; p < N_PROGS; p++) begin
		prog_len[p] = 0;
		for (int k = 0; k < PROG_WORDS; k++)
			prog_mem[p][k] = 32'h0000_0013;	// addi x0,x0,0
	end
	// Program 0 chains ALU ops fed from MEM or WB
	emit(0, i_word(OP_IMM, 3'b000, 1, 0, 291));	// addi x1,x0,291
	emit(0, i_word(OP_IMM, 3'b000, 2, 1, -5));	// addi x2,x1,-5
	emit(0, r_word(7'h00, 3'b000, 3, 2, 1));	// add  x3,x2,x1
	emit(0, r_word(7'h20, 3'b000, 4, 3, 2));	// sub  x4,x3,x2
	emit(0, r_word(7'h00, 3'b100, 5, 4, 3));	// xor  x5,x4,x3
	emit(0, r_word(7'h00, 3'b001, 6, 5, 4));	// sll  x6,x5,x4
	emit(0, lui_word(7, 20'h80000));		// lui  x7,0x80000
	emit(0, r_word(7'h00, 3'b110, 8, 7, 6));	// or   x8,x7,x6
	emit(0, r_word(7'h20, 3'b101, 9, 8, 4));	// sra  x9,x8,x4
	emit(0, r_word(7'h00, 3'b010, 10, 9, 6));	// slt  x10,x9,x6
	emit(0, r_word(7'h00, 3'b011, 11, 9, 6));	// sltu x11,x9,x6
	emit(0, r_word(7'h00, 3'b000, 12, 10, 10));	// add  x12,x10,x10
	emit(0, r_word(7'h00, 3'b110, 13, 12, 11));	// or   x13,x12,x11
	emit(0, r_word(7'h00, 3'b000, 14, 13, 9));	// add  x14,x13,x9
	emit(0, store_word(14, 0, 64));			// sw   x14,64(x0)
	emit(0, jal_word(0, 0));
	// Program 1 has a load-use on rs1 and then on rs2
	emit(1, i_word(OP_IMM, 3'b000, 5, 0, 100));	// addi x5,x0,100
	emit(1, i_word(OP_LOAD, 3'b010, 1, 0, 32));	// lw   x1,32(x0)
	emit(1, r_word(7'h00, 3'b000, 2, 1, 5));	// add  x2,x1,x5
	emit(1, store_word(2, 0, 68));			// sw   x2,68(x0)
	emit(1, i_word(OP_LOAD, 3'b010, 3, 0, 32));	// lw   x3,32(x0)
	emit(1, r_word(7'h20, 3'b000, 4, 5, 3));	// sub  x4,x5,x3
	emit(1, store_word(4, 0, 72));			// sw   x4,72(x0)
	emit(1, jal_word(0, 0));
	// Program 2 sums 1..10 and then takes a BNE over two clobbers
	emit(2, i_word(OP_IMM, 3'b000, 1, 0, 0));	// addi x1,x0,0
	emit(2, i_word(OP_IMM, 3'b000, 2, 0, 1));	// addi x2,x0,1
	emit(2, i_word(OP_IMM, 3'b000, 3, 0, 11));	// addi x3,x0,11
	emit(2, r_word(7'h00, 3'b000, 1, 1, 2));	// add  x1,x1,x2 at loop
	emit(2, i_word(OP_IMM, 3'b000, 2, 2, 1));	// addi x2,x2,1
	emit(2, branch_word(3'b100, 2, 3, -8));		// blt  x2,x3,loop
	emit(2, branch_word(3'b001, 1, 0, 12));		// bne  x1,x0,+12
	emit(2, i_word(OP_IMM, 3'b000, 1, 0, 1));	// addi x1,x0,1
	emit(2, i_word(OP_IMM, 3'b000, 1, 0, 2));	// addi x1,x0,2
	emit(2, store_word(1, 0, 76));			// sw   x1,76(x0)
	emit(2, jal_word(0, 0));
	// Program 3 puts marker stores in the shadow slots of JAL and JALR
	emit(3, i_word(OP_IMM, 3'b000, 5, 0, 7));	// addi x5,x0,7
	emit(3, jal_word(1, 12));			// jal  x1,+12
	emit(3, store_word(5, 0, 80));			// sw   x5,80(x0)
	emit(3, store_word(5, 0, 84));			// sw   x5,84(x0)
	emit(3, store_word(1, 0, 88));			// sw   x1,88(x0)
	emit(3, i_word(OP_IMM, 3'b000, 2, 0, 35));	// addi x2,x0,35
	emit(3, i_word(OP_JALR, 3'b000, 3, 2, 1));	// jalr x3,1(x2) lands on 36
	emit(3, store_word(5, 0, 92));			// sw   x5,92(x0)
	emit(3, store_word(5, 0, 96));			// sw   x5,96(x0)
	emit(3, store_word(3, 0, 100));			// sw   x3,100(x0)
	emit(3, jal_word(0, 0));
	// Program 4 doubles a word from con
	emit(4, i_word(OP_LOAD, 3'b010, 1, 0, 32));	// lw   x1,32(x0)
	emit(4, i_word(OP_IMM, 3'b000, 4, 0, 1));	// addi x4,x0,1
	emit(4, i_word(OP_IMM, 3'b000, 5, 0, 2));	// addi x5,x0,2
	emit(4, r_word(7'h00, 3'b000, 2, 1, 1));	// add  x2,x1,x1
	emit(4, store_word(2, 0, 104));			// sw   x2,104(x0)
	emit(4, jal_word(0, 0));
	// Program 5 builds signed and unsigned compare flags against 5
	emit(5, i_word(OP_LOAD, 3'b010, 1, 0, 32));	// lw   x1,32(x0)
	emit(5, i_word(OP_IMM, 3'b000, 2, 0, 5));	// addi x2,x0,5
	emit(5, r_word(7'h00, 3'b010, 10, 1, 2));	// slt  x10,x1,x2
	emit(5, r_word(7'h00, 3'b011, 11, 1, 2));	// sltu x11,x1,x2
	emit(5, i_word(OP_IMM, 3'b000, 12, 0, 0));	// addi x12,x0,0
	emit(5, branch_word(3'b101, 1, 2, 8));		// bge  x1,x2,+8
	emit(5, i_word(OP_IMM, 3'b110, 12, 12, 4));	// ori  x12,x12,4
	emit(5, branch_word(3'b111, 1, 2, 8));		// bgeu x1,x2,+8
	emit(5, i_word(OP_IMM, 3'b110, 12, 12, 8));	// ori  x12,x12,8
	emit(5, r_word(7'h00, 3'b000, 11, 11, 11));	// add  x11,x11,x11
	emit(5, r_word(7'h00, 3'b110, 12, 12, 10));	// or   x12,x12,x10
	emit(5, r_word(7'h00, 3'b110, 12, 12, 11));	// or   x12,x12,x11
	emit(5, store_word(12, 0, 108));		// sw   x12,108(x0)
	emit(5, jal_word(0, 0));
endtask

//////////////////////////////////////////////////
// Expected values from the ISA rules
function automatic logic [31:0] alu_chain_result();
	logic [31:0] xr [1:14];
	xr[1]  = 32'd291;
	xr[2]  = xr[1] - 32'd5;
	xr[3]  = xr[2] + xr[1];
	xr[4]  = xr[3] - xr[2];
	xr[5]  = xr[4] ^ xr[3];
	xr[6]  = xr[5] << xr[4][4:0];
	xr[7]  = 32'h8000_0000;
	xr[8]  = xr[7] | xr[6];
	xr[9]  = $signed(xr[8]) >>> xr[4][4:0];	// Sign fill
	xr[10] = {31'b0, $signed(xr[9]) < $signed(xr[6])};
	xr[11] = {31'b0, xr[9] < xr[6]};
	xr[12] = xr[10] + xr[10];
	xr[13] = xr[12] | xr[11];
	xr[14] = xr[13] + xr[9];
	return xr[14];
endfunction

// Bit 0 SLT, bit 1 SLTU, bits 2/3 set when BGE/BGEU fall through
function automatic logic [31:0] cmp_flags(input logic [31:0] v);
	logic slt;
	logic sltu;
	logic bge_taken;
	logic bgeu_taken;
	slt        = $signed(v) < $signed(32'd5);
	sltu       = v < 32'd5;
	bge_taken  = $signed(v) >= $signed(32'd5);
	bgeu_taken = v >= 32'd5;
	return {28'b0, !bgeu_taken, !bge_taken, sltu, slt};
endfunction

task automatic add_test(input string name, input int prog, input logic pre_en,
	input logic [31:0] pre_val, input int res_word, input logic [31:0] expected);
	test_t tc;
	tc.prog     = prog[2:0];
	tc.pre_en   = pre_en;
	tc.pre_addr = PRELOAD_WORD[7:0];
	tc.pre_val  = pre_val;
	tc.res_addr = res_word[7:0];
	tc.expected = expected;
	tests.push_back(tc);
	test_names.push_back(name);
endtask

task automatic build_tests();
	logic [31:0] r_load;
	logic [31:0] r_con;
	logic [31:0] r_neg;
	logic [31:0] r_pos;
	r_load = $random(seed);
	r_con  = $random(seed);
	r_neg  = $random(seed) | 32'h8000_0000;	// Force negative
	r_pos  = $random(seed) & 32'h7fff_ffff;
	add_test("alu_chain", 0, 1'b0, '0, 16, alu_chain_result());
	add_test("load_use_rs1", 1, 1'b1, r_load, 17, r_load + 32'd100);
	add_test("load_use_rs2", 1, 1'b1, r_load, 18, 32'd100 - r_load);
	add_test("loop_sum", 2, 1'b0, '0, 19, 32'd55);
	add_test("jal_slot1", 3, 1'b0, '0, 20, 32'd0);
	add_test("jal_slot2", 3, 1'b0, '0, 21, 32'd0);
	add_test("jal_link", 3, 1'b0, '0, 22, 32'd8);	// pc 4 + 4
	add_test("jalr_slot1", 3, 1'b0, '0, 23, 32'd0);
	add_test("jalr_slot2", 3, 1'b0, '0, 24, 32'd0);
	add_test("jalr_link", 3, 1'b0, '0, 25, 32'd28);	// pc 24 + 4
	add_test("con_double", 4, 1'b1, r_con, 26, r_con + r_con);
	add_test("cmp_negative", 5, 1'b1, r_neg, 27, cmp_flags(r_neg));
	add_test("cmp_positive", 5, 1'b1, r_pos, 27, cmp_flags(r_pos));
endtask

`endif

// ==== sim/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb;

	localparam int IMEM_WORDS  = 256;
	localparam int DMEM_WORDS  = 256;
	localparam int IAW         = $clog2(IMEM_WORDS);
	localparam int DAW         = $clog2(DMEM_WORDS);
	localparam int CLK_NS      = 20;
	localparam int RUN_CYCLES  = 200;	// Free run after reset
	localparam int TEST_CYCLES = 260;	// Upper bound per test with load and check

	logic           clk;
	logic           rst_n;
	logic           imem_we;
	logic [IAW-1:0] imem_addr;
	logic [31:0]    imem_wdata;
	logic           con_we;
	logic [DAW-1:0] con_addr;
	logic [31:0]    con_wdata;
	logic [31:0]    con_rdata;
	integer         seed;
	int             n_tests;

	`include "core_tb_programs.svh"

	core #(
		.IMEM_WORDS (IMEM_WORDS),
		.DMEM_WORDS (DMEM_WORDS)
	) core_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.con_we     (con_we),
		.con_addr   (con_addr),
		.con_wdata  (con_wdata),
		.con_rdata  (con_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// One test loads under reset, runs and reads back
	task automatic run_test(input test_t tc, output logic [31:0] got);
		@(posedge clk);
		rst_n <= 1'b0;
		// Program in while data words 0..31 are wiped
		for (int k = 0; k < PROG_WORDS; k++) begin
			@(posedge clk);
			imem_we    <= 1'b1;
			imem_addr  <= IAW'(k);
			imem_wdata <= prog_mem[tc.prog][k];
			con_we     <= 1'b1;
			con_addr   <= DAW'(k);
			con_wdata  <= '0;
		end
		@(posedge clk);
		imem_we   <= 1'b0;
		con_we    <= tc.pre_en;	// Optional operand word
		con_addr  <= tc.pre_addr;
		con_wdata <= tc.pre_val;
		@(posedge clk);
		con_we <= 1'b0;
		repeat (2) @(posedge clk);	// Reset with ports idle
		rst_n <= 1'b1;
		repeat (RUN_CYCLES) @(posedge clk);
		con_addr <= tc.res_addr;
		@(posedge clk);	// Read registered here
		@(negedge clk);
		got = con_rdata;
	endtask

	// Watchdog
	initial begin
		wait (n_tests > 0);
		#(n_tests * TEST_CYCLES * CLK_NS * 2);
		$display("Run timed out after %0d cycles", n_tests * TEST_CYCLES * 2);
		$display("Something failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Main sequence
	initial begin
		test_t       tc;
		logic [31:0] got;
		int          n_pass;
		int          n_fail;
		rst_n      = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		con_we     = 1'b0;
		con_addr   = '0;
		con_wdata  = '0;
		seed       = 99328;
		n_pass     = 0;
		n_fail     = 0;
		build_programs();
		build_tests();	// Draws the random operands
		n_tests = tests.size();
		for (int t = 0; t < n_tests; t++) begin
			tc = tests[t];
			run_test(tc, got);
			if (got !== tc.expected) begin
				$display("ERR %s expected %h actual %h", test_names[t], tc.expected, got);
				n_fail++;
			end else begin
				$display("ok  %s value %h", test_names[t], got);
				n_pass++;
			end
		end
		$display("Tests run %0d, passed %0d, failed %0d", n_tests, n_pass, n_fail);
		if (n_fail == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+sim
design/riscv_isa_pkg.sv
design/core_pkg.sv
design/regfile.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/hazard_unit.sv
design/core.sv
sim/core_tb.sv
